// ==== dac_channel_regs.sv ====
// One DAC channel page; configuration is applied in up_clk with no crossing to the link clock
`timescale 1ns/10ps

module dac_channel_regs #(
  parameter int CHANNEL_NUMBER = 0
) (
  input  logic                   up_clk,
  input  logic                   up_rstn,
  input  tpl_dac_pkg::up_req_t   up_req,
  output tpl_dac_pkg::up_rsp_t   up_rsp,
  output tpl_dac_pkg::chan_cfg_t chan_cfg
);

  // Page of this channel
  localparam logic [tpl_dac_pkg::PAGE_W-1:0] CHAN_PAGE =
    tpl_dac_pkg::PAGE_CHAN_BASE + tpl_dac_pkg::PAGE_W'(CHANNEL_NUMBER);

  logic                              wr_hit;
  logic                              rd_hit;
  logic [tpl_dac_pkg::OFFS_W-1:0]    wr_offs;
  logic [tpl_dac_pkg::OFFS_W-1:0]    rd_offs;
  logic [tpl_dac_pkg::DATA_W-1:0]    rd_mux;

  assign wr_hit  = up_req.wreq && (tpl_dac_pkg::addr_page(up_req.waddr) == CHAN_PAGE);
  assign rd_hit  = up_req.rreq && (tpl_dac_pkg::addr_page(up_req.raddr) == CHAN_PAGE);
  assign wr_offs = tpl_dac_pkg::addr_offs(up_req.waddr);
  assign rd_offs = tpl_dac_pkg::addr_offs(up_req.raddr);

  // ******************************
  // Register writes
  // ******************************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rsp   <= '0;
      chan_cfg <= '0;
    end else begin
      up_rsp.wack  <= wr_hit;
      up_rsp.rack  <= rd_hit;
      up_rsp.rdata <= rd_hit ? rd_mux : '0;
      if (wr_hit) begin
        case (wr_offs)
          tpl_dac_pkg::CH_OFFS_SCALE: begin
            chan_cfg.dds_scale_1 <= up_req.wdata[31:16];
            chan_cfg.dds_scale_0 <= up_req.wdata[15:0];
          end
          tpl_dac_pkg::CH_OFFS_INIT: begin
            chan_cfg.dds_init_1 <= up_req.wdata[31:16];
            chan_cfg.dds_init_0 <= up_req.wdata[15:0];
          end
          tpl_dac_pkg::CH_OFFS_INCR: begin
            chan_cfg.dds_incr_1 <= up_req.wdata[31:16];
            chan_cfg.dds_incr_0 <= up_req.wdata[15:0];
          end
          tpl_dac_pkg::CH_OFFS_PAT: begin
            chan_cfg.pat_data_1 <= up_req.wdata[31:16];
            chan_cfg.pat_data_0 <= up_req.wdata[15:0];
          end
          tpl_dac_pkg::CH_OFFS_SEL: begin
            chan_cfg.data_sel     <= up_req.wdata[3:0];
            chan_cfg.mask_enable  <= up_req.wdata[8];
            chan_cfg.src_chan_sel <= up_req.wdata[23:16];
          end
          default: ;
        endcase
      end
    end
  end

  // ******************************
  // Read mux
  // ******************************
  always_comb begin
    rd_mux = '0;
    case (rd_offs)
      tpl_dac_pkg::CH_OFFS_SCALE: rd_mux = {chan_cfg.dds_scale_1, chan_cfg.dds_scale_0};
      tpl_dac_pkg::CH_OFFS_INIT:  rd_mux = {chan_cfg.dds_init_1, chan_cfg.dds_init_0};
      tpl_dac_pkg::CH_OFFS_INCR:  rd_mux = {chan_cfg.dds_incr_1, chan_cfg.dds_incr_0};
      tpl_dac_pkg::CH_OFFS_PAT:   rd_mux = {chan_cfg.pat_data_1, chan_cfg.pat_data_0};
      // Undefined bits in the select word read zero
      tpl_dac_pkg::CH_OFFS_SEL: begin
        rd_mux = {8'd0, chan_cfg.src_chan_sel, 7'd0, chan_cfg.mask_enable,
                  4'd0, chan_cfg.data_sel};
      end
      default: rd_mux = '0;
    endcase
  end

endmodule

// ==== dac_common_regs.sv ====
// Common DAC page; dac_rst stays asserted until software sets the release bit
`timescale 1ns/10ps

module dac_common_regs (
  input  logic                 up_clk,
  input  logic                 up_rstn,
  input  tpl_dac_pkg::up_req_t up_req,
  input  logic                 dac_dunf,
  input  logic                 dac_sync_in_status,
  output tpl_dac_pkg::up_rsp_t up_rsp,
  output logic                 dac_rst,
  output logic                 dac_sync,
  output logic                 dac_dds_format
);

  logic                              wr_hit;
  logic                              rd_hit;
  logic [tpl_dac_pkg::OFFS_W-1:0]    wr_offs;
  logic [tpl_dac_pkg::OFFS_W-1:0]    rd_offs;
  logic [tpl_dac_pkg::DATA_W-1:0]    scratch;
  logic                              rst_release;
  logic                              dunf_sticky;
  logic [tpl_dac_pkg::DATA_W-1:0]    rd_mux;

  assign wr_hit  = up_req.wreq &&
                   (tpl_dac_pkg::addr_page(up_req.waddr) == tpl_dac_pkg::PAGE_COMMON);
  assign rd_hit  = up_req.rreq &&
                   (tpl_dac_pkg::addr_page(up_req.raddr) == tpl_dac_pkg::PAGE_COMMON);
  assign wr_offs = tpl_dac_pkg::addr_offs(up_req.waddr);
  assign rd_offs = tpl_dac_pkg::addr_offs(up_req.raddr);

  // ******************************
  // Register writes
  // ******************************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rsp         <= '0;
      scratch        <= '0;
      rst_release    <= 1'b0;
      dac_sync       <= 1'b0;
      dac_dds_format <= 1'b0;
      dunf_sticky    <= 1'b0;
    end else begin
      up_rsp.wack  <= wr_hit;
      up_rsp.rack  <= rd_hit;
      up_rsp.rdata <= rd_hit ? rd_mux : '0;
      dac_sync     <= 1'b0;
      if (wr_hit) begin
        case (wr_offs)
          tpl_dac_pkg::OFFS_SCRATCH: scratch <= up_req.wdata;
          tpl_dac_pkg::OFFS_RESET:   rst_release <= up_req.wdata[0];
          tpl_dac_pkg::OFFS_SYNC:    dac_sync <= up_req.wdata[0];
          tpl_dac_pkg::OFFS_FORMAT:  dac_dds_format <= up_req.wdata[0];
          default: ;
        endcase
      end
      // Underflow set wins over a clear in the same cycle
      if (wr_hit && (wr_offs == tpl_dac_pkg::OFFS_STATUS) && up_req.wdata[1]) begin
        dunf_sticky <= 1'b0;
      end
      if (dac_dunf) begin
        dunf_sticky <= 1'b1;
      end
    end
  end

  // ******************************
  // Read mux
  // ******************************
  always_comb begin
    rd_mux = '0;
    case (rd_offs)
      tpl_dac_pkg::OFFS_VERSION: rd_mux = tpl_dac_pkg::CORE_VERSION;
      tpl_dac_pkg::OFFS_SCRATCH: rd_mux = scratch;
      tpl_dac_pkg::OFFS_RESET:   rd_mux = {31'd0, rst_release};
      // Sync is a strobe and reads back zero
      tpl_dac_pkg::OFFS_SYNC:    rd_mux = '0;
      tpl_dac_pkg::OFFS_FORMAT:  rd_mux = {31'd0, dac_dds_format};
      tpl_dac_pkg::OFFS_STATUS:  rd_mux = {30'd0, dunf_sticky, dac_sync_in_status};
      default:                   rd_mux = '0;
    endcase
  end

  assign dac_rst = ~rst_release;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register map testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tpl_dac_regmap_sim

verilator --binary --assert --top-module tpl_dac_regmap_tb -f verilog.f -o tpl_dac_regmap_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# A failed assertion must not stop the run before the testbench gives its verdict
"$BIN" +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== tpl_dac_pkg.sv ====
// Shared map and bus types; everything lives in the up_clk domain and uses 32-bit word access
package tpl_dac_pkg;

  // ******************************
  // Sizes
  // ******************************

  localparam int NUM_CHANNELS = 2;
  localparam int NUM_PROFILES = 2;
  // One bit wider than the profile count needs
  localparam int PROFILE_SEL_W = $clog2(NUM_PROFILES) + 1;

  localparam int ADDR_W = 11;
  localparam int DATA_W = 32;
  localparam int PAGE_W = 7;
  localparam int OFFS_W = 4;

  // ******************************
  // Address map
  // ******************************

  localparam logic [PAGE_W-1:0] PAGE_COMMON    = 7'h00;
  localparam logic [PAGE_W-1:0] PAGE_CHAN_BASE = 7'h01;
  localparam logic [PAGE_W-1:0] PAGE_TPL       = 7'h10;

  // Common page
  localparam logic [OFFS_W-1:0] OFFS_VERSION = 4'h0;
  localparam logic [OFFS_W-1:0] OFFS_SCRATCH = 4'h1;
  localparam logic [OFFS_W-1:0] OFFS_RESET   = 4'h2;
  localparam logic [OFFS_W-1:0] OFFS_SYNC    = 4'h3;
  localparam logic [OFFS_W-1:0] OFFS_FORMAT  = 4'h4;
  localparam logic [OFFS_W-1:0] OFFS_STATUS  = 4'h5;

  // Channel page
  localparam logic [OFFS_W-1:0] CH_OFFS_SCALE = 4'h0;
  localparam logic [OFFS_W-1:0] CH_OFFS_INIT  = 4'h1;
  localparam logic [OFFS_W-1:0] CH_OFFS_INCR  = 4'h2;
  localparam logic [OFFS_W-1:0] CH_OFFS_PAT   = 4'h3;
  localparam logic [OFFS_W-1:0] CH_OFFS_SEL   = 4'h4;

  // Transport page
  localparam logic [OFFS_W-1:0] TPL_OFFS_NPROF  = 4'h0;
  localparam logic [OFFS_W-1:0] TPL_OFFS_SEL    = 4'h1;
  localparam logic [OFFS_W-1:0] TPL_OFFS_PARAM0 = 4'h2;
  localparam logic [OFFS_W-1:0] TPL_OFFS_PARAM1 = 4'h3;

  localparam logic [DATA_W-1:0] CORE_VERSION = 32'h0001_0061;

  // Bridge gives up on a silent page after this many cycles
  localparam int TIMEOUT_CYCLES = 16;
  localparam int TIMEOUT_W = $clog2(TIMEOUT_CYCLES + 1);

  // ******************************
  // Bus and payload types
  // ******************************

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
    logic [3:0]        sel;
  } wb_m2s_t;

  typedef struct packed {
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] dat;
  } wb_s2m_t;

  typedef struct packed {
    logic              wreq;
    logic [ADDR_W-1:0] waddr;
    logic [DATA_W-1:0] wdata;
    logic              rreq;
    logic [ADDR_W-1:0] raddr;
  } up_req_t;

  typedef struct packed {
    logic              wack;
    logic              rack;
    logic [DATA_W-1:0] rdata;
  } up_rsp_t;

  typedef struct packed {
    logic [15:0] dds_scale_0;
    logic [15:0] dds_scale_1;
    logic [15:0] dds_init_0;
    logic [15:0] dds_init_1;
    logic [15:0] dds_incr_0;
    logic [15:0] dds_incr_1;
    logic [15:0] pat_data_0;
    logic [15:0] pat_data_1;
    logic [3:0]  data_sel;
    logic        mask_enable;
    logic [7:0]  src_chan_sel;
  } chan_cfg_t;

  typedef struct packed {
    logic [7:0] m;
    logic [7:0] l;
    logic [7:0] s;
    logic [7:0] f;
    logic [7:0] n;
    logic [7:0] np;
  } jesd_prof_t;

  // Page is the upper address bits, offset the lower four
  function automatic logic [PAGE_W-1:0] addr_page(input logic [ADDR_W-1:0] addr);
    return addr[ADDR_W-1:OFFS_W];
  endfunction

  function automatic logic [OFFS_W-1:0] addr_offs(input logic [ADDR_W-1:0] addr);
    return addr[OFFS_W-1:0];
  endfunction

endpackage

// ==== tpl_dac_regmap.sv ====
// Register map top; all outputs are in up_clk, fixed 4-cycle Wishbone latency for mapped pages
`timescale 1ns/10ps

module tpl_dac_regmap (
  input  logic                                                    up_clk,
  input  logic                                                    up_rstn,
  input  tpl_dac_pkg::wb_m2s_t                                    wb_req,
  input  logic                                                    dac_dunf,
  input  logic                                                    dac_sync_in_status,
  input  tpl_dac_pkg::jesd_prof_t [tpl_dac_pkg::NUM_PROFILES-1:0] jesd_prof,
  output tpl_dac_pkg::wb_s2m_t                                    wb_rsp,
  output logic                                                    dac_rst,
  output logic                                                    dac_sync,
  output logic                                                    dac_dds_format,
  output tpl_dac_pkg::chan_cfg_t [tpl_dac_pkg::NUM_CHANNELS-1:0]  chan_cfg,
  output logic [tpl_dac_pkg::PROFILE_SEL_W-1:0]                   up_profile_sel
);

  tpl_dac_pkg::up_req_t                                   up_req;
  // Registered response seen by the bridge
  tpl_dac_pkg::up_rsp_t                                   up_rsp;
  tpl_dac_pkg::up_rsp_t                                   rsp_common;
  tpl_dac_pkg::up_rsp_t                                   rsp_tpl;
  tpl_dac_pkg::up_rsp_t [tpl_dac_pkg::NUM_CHANNELS-1:0]   rsp_chan;
  tpl_dac_pkg::up_rsp_t                                   rsp_all;

  wb_up_bridge wb_up_bridge_inst (
    .up_clk  (up_clk),
    .up_rstn (up_rstn),
    .wb_req  (wb_req),
    .up_rsp  (up_rsp),
    .wb_rsp  (wb_rsp),
    .up_req  (up_req)
  );

  // ******************************
  // Register pages
  // ******************************
  dac_common_regs dac_common_regs_inst (
    .up_clk             (up_clk),
    .up_rstn            (up_rstn),
    .up_req             (up_req),
    .dac_dunf           (dac_dunf),
    .dac_sync_in_status (dac_sync_in_status),
    .up_rsp             (rsp_common),
    .dac_rst            (dac_rst),
    .dac_sync           (dac_sync),
    .dac_dds_format     (dac_dds_format)
  );

  for (genvar i = 0; i < tpl_dac_pkg::NUM_CHANNELS; i++) begin : g_channel
    dac_channel_regs #(
      .CHANNEL_NUMBER (i)
    ) dac_channel_regs_inst (
      .up_clk   (up_clk),
      .up_rstn  (up_rstn),
      .up_req   (up_req),
      .up_rsp   (rsp_chan[i]),
      .chan_cfg (chan_cfg[i])
    );
  end

  tpl_profile_regs tpl_profile_regs_inst (
    .up_clk         (up_clk),
    .up_rstn        (up_rstn),
    .up_req         (up_req),
    .jesd_prof      (jesd_prof),
    .up_rsp         (rsp_tpl),
    .up_profile_sel (up_profile_sel)
  );

  // Idle pages drive zero, so a plain OR merges them
  always_comb begin
    rsp_all = rsp_common | rsp_tpl;
    for (int i = 0; i < tpl_dac_pkg::NUM_CHANNELS; i++) begin
      rsp_all = rsp_all | rsp_chan[i];
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rsp <= '0;
    end else begin
      up_rsp <= rsp_all;
    end
  end

endmodule

// ==== tpl_dac_regmap_assert.sv ====
// Handshake and latency properties of the register map; latency is checked for mapped pages only
`timescale 1ns/10ps

module tpl_dac_regmap_assert (
  input logic                 up_clk,
  input logic                 up_rstn,
  input tpl_dac_pkg::wb_m2s_t wb_req,
  input tpl_dac_pkg::wb_s2m_t wb_rsp,
  input logic                 dac_rst,
  input logic                 dac_sync
);

  logic                           strobe;
  logic                           strobe_q;
  logic                           mapped;
  logic                           start_mapped;
  logic [tpl_dac_pkg::PAGE_W-1:0] page;
  // Sticky flags, one per property
  logic                           fail_strobe = 1'b0;
  logic                           fail_latency = 1'b0;
  logic                           fail_both = 1'b0;
  logic                           fail_sync = 1'b0;
  logic                           fail_reset = 1'b0;
  logic                           failed;

  assign strobe       = wb_req.cyc && wb_req.stb;
  assign page         = wb_req.adr[tpl_dac_pkg::ADDR_W-1:tpl_dac_pkg::OFFS_W];
  assign mapped       = (page == tpl_dac_pkg::PAGE_COMMON) || (page == tpl_dac_pkg::PAGE_TPL) ||
                        ((page >= tpl_dac_pkg::PAGE_CHAN_BASE) && (page <
                         tpl_dac_pkg::PAGE_CHAN_BASE + 7'(tpl_dac_pkg::NUM_CHANNELS)));
  assign start_mapped = strobe && !strobe_q && mapped;
  assign failed       = fail_strobe | fail_latency | fail_both | fail_sync | fail_reset;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= strobe;
    end
  end

  // ******************************
  assert property (@(posedge up_clk) disable iff (!up_rstn)
                   (wb_rsp.ack || wb_rsp.err) |-> $past(strobe))
    else begin fail_strobe = 1'b1; $error("ack or err without a held strobe"); end

  assert property (@(posedge up_clk) disable iff (!up_rstn)
                   wb_rsp.ack == $past(start_mapped, 4))
    else begin fail_latency = 1'b1; $error("ack not exactly 4 cycles after the strobe"); end

  assert property (@(posedge up_clk) disable iff (!up_rstn) !(wb_rsp.ack && wb_rsp.err))
    else begin fail_both = 1'b1; $error("ack and err high together"); end

  assert property (@(posedge up_clk) disable iff (!up_rstn) dac_sync |=> !dac_sync)
    else begin fail_sync = 1'b1; $error("dac_sync high for two cycles"); end

  assert property (@(posedge up_clk) $rose(up_rstn) |-> (dac_rst && !dac_sync))
    else begin fail_reset = 1'b1; $error("wrong dac_rst or dac_sync after reset"); end

endmodule

bind tpl_dac_regmap tpl_dac_regmap_assert tpl_dac_regmap_assert_inst (
  .up_clk   (up_clk),
  .up_rstn  (up_rstn),
  .wb_req   (wb_req),
  .wb_rsp   (wb_rsp),
  .dac_rst  (dac_rst),
  .dac_sync (dac_sync)
);

// ==== tpl_dac_regmap_tb.sv ====
// Testbench for the register map; fixed seed 19, each access must end within the cycle limit
`timescale 1ns/10ps

module tpl_dac_regmap_tb;

  localparam int MAX_CYCLES = 2000;
  localparam int NUM_OFFS   = 5;

  logic                                                    up_clk;
  logic                                                    up_rstn;
  tpl_dac_pkg::wb_m2s_t                                    wb_req;
  logic                                                    dac_dunf;
  logic                                                    dac_sync_in_status;
  tpl_dac_pkg::jesd_prof_t [tpl_dac_pkg::NUM_PROFILES-1:0] jesd_prof;
  tpl_dac_pkg::wb_s2m_t                                    wb_rsp;
  logic                                                    dac_rst;
  logic                                                    dac_sync;
  logic                                                    dac_dds_format;
  tpl_dac_pkg::chan_cfg_t [tpl_dac_pkg::NUM_CHANNELS-1:0]  chan_cfg;
  logic [tpl_dac_pkg::PROFILE_SEL_W-1:0]                   up_profile_sel;
  int                                                      cycles = 0;
  int                                                      sync_pulses = 0;
  logic [31:0]              chan_words [tpl_dac_pkg::NUM_CHANNELS][NUM_OFFS];

  tpl_dac_regmap tpl_dac_regmap_inst (
    .up_clk             (up_clk),
    .up_rstn            (up_rstn),
    .wb_req             (wb_req),
    .dac_dunf           (dac_dunf),
    .dac_sync_in_status (dac_sync_in_status),
    .jesd_prof          (jesd_prof),
    .wb_rsp             (wb_rsp),
    .dac_rst            (dac_rst),
    .dac_sync           (dac_sync),
    .dac_dds_format     (dac_dds_format),
    .chan_cfg           (chan_cfg),
    .up_profile_sel     (up_profile_sel)
  );

  initial up_clk = 1'b0;
  always #50 up_clk = ~up_clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic compare(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
    assert (actual === expected) else begin
      stop_with_failure($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h",
                                  test, expected, actual));
    end
  endtask

  // Watchdog and protocol monitor
  always @(posedge up_clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      stop_with_failure($sformatf("Timeout: run exceeded %0d cycles", MAX_CYCLES));
    end
  end

  always @(negedge up_clk) begin
    if (up_rstn && dac_sync) begin
      sync_pulses++;
    end
    if (tpl_dac_regmap_inst.tpl_dac_regmap_assert_inst.failed) begin
      stop_with_failure("A bound assertion on the register map failed");
    end
  end

  function automatic logic [tpl_dac_pkg::ADDR_W-1:0] reg_addr(input logic [6:0] page,
                                                              input logic [3:0] offs);
    return {page, offs};
  endfunction

  function automatic logic [6:0] chan_page(input int ch);
    return tpl_dac_pkg::PAGE_CHAN_BASE + 7'(ch);
  endfunction

  // Channel port fields packed the way the register map places them
  function automatic logic [31:0] chan_port_word(input int ch, input int offs);
    tpl_dac_pkg::chan_cfg_t c;
    c = chan_cfg[ch];
    case (offs)
      0:       return {c.dds_scale_1, c.dds_scale_0};
      1:       return {c.dds_init_1, c.dds_init_0};
      2:       return {c.dds_incr_1, c.dds_incr_0};
      3:       return {c.pat_data_1, c.pat_data_0};
      default: return {8'd0, c.src_chan_sel, 7'd0, c.mask_enable, 4'd0, c.data_sel};
    endcase
  endfunction

  // One Wishbone classic cycle, held until ack or err
  task automatic transfer(input logic we, input logic [tpl_dac_pkg::ADDR_W-1:0] adr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic got_err);
    @(negedge up_clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdata;
    wb_req.sel = 4'hF;
    do begin
      @(negedge up_clk);
    end while (!(wb_rsp.ack || wb_rsp.err));
    rdata   = wb_rsp.dat;
    got_err = wb_rsp.err;
    wb_req  = '0;
  endtask

  task automatic write_word(input string test, input logic [tpl_dac_pkg::ADDR_W-1:0] adr,
                            input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        got_err;
    transfer(1'b1, adr, wdata, rdata, got_err);
    compare({test, " write err"}, 32'd0, 32'(got_err));
  endtask

  task automatic read_expect(input string test, input logic [tpl_dac_pkg::ADDR_W-1:0] adr,
                             input logic [31:0] expected);
    logic [31:0] rdata;
    logic        got_err;
    transfer(1'b0, adr, 32'd0, rdata, got_err);
    compare({test, " read err"}, 32'd0, 32'(got_err));
    compare(test, expected, rdata);
  endtask

  initial begin
    logic [31:0] word;
    logic [31:0] scratch_word;
    logic [31:0] rdata;
    logic        got_err;
    void'($urandom(19));
    up_rstn            = 1'b0;
    wb_req             = '0;
    dac_dunf           = 1'b0;
    dac_sync_in_status = 1'b0;
    jesd_prof          = '0;
    repeat (4) @(negedge up_clk);
    up_rstn = 1'b1;

    // ******************************
    // Reset values
    assert (chan_cfg === '0) else begin
      stop_with_failure($sformatf("Mismatch in reset_chan_cfg: expected 0x0, actual 0x%0h",
                                  chan_cfg));
    end
    compare("reset_dac_rst", 32'd1, 32'(dac_rst));
    compare("reset_profile_sel", 32'd0, 32'(up_profile_sel));
    read_expect("reset_version", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h0),
                tpl_dac_pkg::CORE_VERSION);

    // ******************************
    // Read back
    scratch_word = $urandom;
    write_word("scratch", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h1), scratch_word);
    read_expect("scratch", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h1), scratch_word);
    for (int ch = 0; ch < tpl_dac_pkg::NUM_CHANNELS; ch++) begin
      for (int o = 0; o < NUM_OFFS; o++) begin
        word = $urandom;
        // Offset 4 keeps data_sel, mask_enable and src_chan_sel only
        chan_words[ch][o] = (o == 4) ? (word & 32'h00FF_010F) : word;
        write_word($sformatf("chan%0d_offs%0d", ch, o), reg_addr(chan_page(ch), 4'(o)), word);
        read_expect($sformatf("chan%0d_offs%0d", ch, o), reg_addr(chan_page(ch), 4'(o)),
                    chan_words[ch][o]);
        compare($sformatf("chan%0d_port%0d", ch, o), chan_words[ch][o], chan_port_word(ch, o));
      end
    end
    for (int ch = 0; ch < tpl_dac_pkg::NUM_CHANNELS; ch++) begin
      for (int o = 0; o < NUM_OFFS; o++) begin
        read_expect($sformatf("chan%0d_keep%0d", ch, o), reg_addr(chan_page(ch), 4'(o)),
                    chan_words[ch][o]);
      end
    end

    // ******************************
    // Control and status
    write_word("reset_release", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h2), 32'd1);
    compare("reset_release_port", 32'd0, 32'(dac_rst));
    read_expect("reset_release", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h2), 32'd1);
    write_word("sync", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h3), 32'd1);
    compare("sync_pulses", 32'd1, 32'(sync_pulses));
    read_expect("sync_reads_zero", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h3), 32'd0);
    write_word("format", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h4), 32'd1);
    compare("format_port", 32'd1, 32'(dac_dds_format));
    read_expect("format", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h4), 32'd1);
    @(negedge up_clk);
    dac_dunf = 1'b1;
    @(negedge up_clk);
    dac_dunf = 1'b0;
    read_expect("status_dunf", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h5), 32'd2);
    write_word("status_clear", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h5), 32'd2);
    read_expect("status_cleared", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h5), 32'd0);
    dac_sync_in_status = 1'b1;
    read_expect("status_sync_in", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h5), 32'd1);

    // ******************************
    // Profiles
    // Every byte differs from the previous profile
    jesd_prof[0] = {$urandom, 16'($urandom)};
    for (int p = 1; p < tpl_dac_pkg::NUM_PROFILES; p++) begin
      for (int b = 0; b < 6; b++) begin
        jesd_prof[p][8*b +: 8] = jesd_prof[p-1][8*b +: 8] ^ 8'($urandom_range(255, 1));
      end
    end
    read_expect("profile_count", reg_addr(tpl_dac_pkg::PAGE_TPL, 4'h0),
                32'(tpl_dac_pkg::NUM_PROFILES));
    for (int p = 0; p < tpl_dac_pkg::NUM_PROFILES; p++) begin
      write_word("profile_select", reg_addr(tpl_dac_pkg::PAGE_TPL, 4'h1), 32'(p));
      read_expect("profile_select", reg_addr(tpl_dac_pkg::PAGE_TPL, 4'h1), 32'(p));
      read_expect($sformatf("profile%0d_param0", p), reg_addr(tpl_dac_pkg::PAGE_TPL, 4'h2),
                  {jesd_prof[p].m, jesd_prof[p].l, jesd_prof[p].s, jesd_prof[p].f});
      read_expect($sformatf("profile%0d_param1", p), reg_addr(tpl_dac_pkg::PAGE_TPL, 4'h3),
                  {16'd0, jesd_prof[p].n, jesd_prof[p].np});
    end
    write_word("profile_range", reg_addr(tpl_dac_pkg::PAGE_TPL, 4'h1),
               32'(tpl_dac_pkg::NUM_PROFILES));
    read_expect("profile_range", reg_addr(tpl_dac_pkg::PAGE_TPL, 4'h1),
                32'(tpl_dac_pkg::NUM_PROFILES - 1));
    compare("profile_port", 32'(tpl_dac_pkg::NUM_PROFILES - 1), 32'(up_profile_sel));

    // ******************************
    // Unused offsets and unmapped pages
    read_expect("unused_chan_offs", reg_addr(chan_page(0), 4'h9), 32'd0);
    read_expect("unused_tpl_offs", reg_addr(tpl_dac_pkg::PAGE_TPL, 4'hF), 32'd0);
    // Version read leaves nonzero data in the bridge before each err
    read_expect("before_unmapped_write", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h0),
                tpl_dac_pkg::CORE_VERSION);
    transfer(1'b1, reg_addr(7'h20, 4'h0), $urandom, rdata, got_err);
    compare("unmapped_write_err", 32'd1, 32'(got_err));
    compare("unmapped_write_data", 32'd0, rdata);
    read_expect("before_unmapped_read", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h0),
                tpl_dac_pkg::CORE_VERSION);
    transfer(1'b0, reg_addr(7'h20, 4'h3), 32'd0, rdata, got_err);
    compare("unmapped_read_err", 32'd1, 32'(got_err));
    compare("unmapped_read_data", 32'd0, rdata);
    read_expect("after_unmapped", reg_addr(tpl_dac_pkg::PAGE_COMMON, 4'h1), scratch_word);

    if (tpl_dac_regmap_inst.tpl_dac_regmap_assert_inst.failed) begin
      stop_with_failure("A bound assertion on the register map failed");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// ==== tpl_profile_regs.sv ====
// Transport page; profile select only takes values below NUM_PROFILES
`timescale 1ns/10ps

module tpl_profile_regs (
  input  logic                                                  up_clk,
  input  logic                                                  up_rstn,
  input  tpl_dac_pkg::up_req_t                                  up_req,
  input  tpl_dac_pkg::jesd_prof_t [tpl_dac_pkg::NUM_PROFILES-1:0] jesd_prof,
  output tpl_dac_pkg::up_rsp_t                                  up_rsp,
  output logic [tpl_dac_pkg::PROFILE_SEL_W-1:0]                 up_profile_sel
);

  logic                              wr_hit;
  logic                              rd_hit;
  logic [tpl_dac_pkg::OFFS_W-1:0]    wr_offs;
  logic [tpl_dac_pkg::OFFS_W-1:0]    rd_offs;
  logic                              sel_valid;
  tpl_dac_pkg::jesd_prof_t           prof_cur;
  logic [tpl_dac_pkg::DATA_W-1:0]    rd_mux;

  assign wr_hit    = up_req.wreq &&
                     (tpl_dac_pkg::addr_page(up_req.waddr) == tpl_dac_pkg::PAGE_TPL);
  assign rd_hit    = up_req.rreq &&
                     (tpl_dac_pkg::addr_page(up_req.raddr) == tpl_dac_pkg::PAGE_TPL);
  assign wr_offs   = tpl_dac_pkg::addr_offs(up_req.waddr);
  assign rd_offs   = tpl_dac_pkg::addr_offs(up_req.raddr);
  assign sel_valid = up_req.wdata < tpl_dac_pkg::DATA_W'(tpl_dac_pkg::NUM_PROFILES);

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rsp         <= '0;
      up_profile_sel <= '0;
    end else begin
      up_rsp.wack  <= wr_hit;
      up_rsp.rack  <= rd_hit;
      up_rsp.rdata <= rd_hit ? rd_mux : '0;
      // Out of range selects keep the old profile
      if (wr_hit && (wr_offs == tpl_dac_pkg::TPL_OFFS_SEL) && sel_valid) begin
        up_profile_sel <= up_req.wdata[tpl_dac_pkg::PROFILE_SEL_W-1:0];
      end
    end
  end

  // Parameters of the selected profile
  always_comb begin
    prof_cur = '0;
    for (int p = 0; p < tpl_dac_pkg::NUM_PROFILES; p++) begin
      if (up_profile_sel == tpl_dac_pkg::PROFILE_SEL_W'(p)) begin
        prof_cur = jesd_prof[p];
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    case (rd_offs)
      tpl_dac_pkg::TPL_OFFS_NPROF:  rd_mux = tpl_dac_pkg::DATA_W'(tpl_dac_pkg::NUM_PROFILES);
      tpl_dac_pkg::TPL_OFFS_SEL:    rd_mux = tpl_dac_pkg::DATA_W'(up_profile_sel);
      tpl_dac_pkg::TPL_OFFS_PARAM0: rd_mux = {prof_cur.m, prof_cur.l, prof_cur.s, prof_cur.f};
      tpl_dac_pkg::TPL_OFFS_PARAM1: rd_mux = {16'd0, prof_cur.n, prof_cur.np};
      default:                      rd_mux = '0;
    endcase
  end

endmodule

// ==== verilog.f ====
tpl_dac_pkg.sv
wb_up_bridge.sv
dac_common_regs.sv
dac_channel_regs.sv
tpl_profile_regs.sv
tpl_dac_regmap.sv
tpl_dac_regmap_assert.sv
tpl_dac_regmap_tb.sv

// ==== wb_up_bridge.sv ====
// Wishbone classic slave, one transaction at a time, sel ignored (full-word writes only)
`timescale 1ns/10ps

module wb_up_bridge (
  input  logic                 up_clk,
  input  logic                 up_rstn,
  input  tpl_dac_pkg::wb_m2s_t wb_req,
  input  tpl_dac_pkg::up_rsp_t up_rsp,
  output tpl_dac_pkg::wb_s2m_t wb_rsp,
  output tpl_dac_pkg::up_req_t up_req
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_DONE
  } state_t;

  state_t                               state;
  logic [tpl_dac_pkg::TIMEOUT_W-1:0]    wait_cnt;
  logic                                 req_wr;
  logic                                 req_rd;
  logic [tpl_dac_pkg::ADDR_W-1:0]       req_addr;
  logic [tpl_dac_pkg::DATA_W-1:0]       req_data;
  logic                                 rsp_ack;
  logic                                 rsp_err;
  logic [tpl_dac_pkg::DATA_W-1:0]       rsp_dat;
  logic                                 start;
  logic                                 resp_in;
  logic                                 expired;

  assign start   = (state == ST_IDLE) && wb_req.cyc && wb_req.stb;
  assign resp_in = up_rsp.wack || up_rsp.rack;
  assign expired = (wait_cnt == tpl_dac_pkg::TIMEOUT_W'(tpl_dac_pkg::TIMEOUT_CYCLES));

  // ******************************
  // Handshake FSM
  // ******************************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
      req_wr   <= 1'b0;
      req_rd   <= 1'b0;
      rsp_ack  <= 1'b0;
      rsp_err  <= 1'b0;
    end else begin
      // Pulses by default
      req_wr  <= 1'b0;
      req_rd  <= 1'b0;
      rsp_ack <= 1'b0;
      rsp_err <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            req_wr   <= wb_req.we;
            req_rd   <= !wb_req.we;
            wait_cnt <= '0;
            state    <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (resp_in) begin
            rsp_ack <= 1'b1;
            state   <= ST_DONE;
          end else if (expired) begin
            rsp_err <= 1'b1;
            state   <= ST_DONE;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        // Master drops stb here
        ST_DONE: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address, write data and read data
  always_ff @(posedge up_clk) begin
    if (start) begin
      req_addr <= wb_req.adr;
      req_data <= wb_req.dat;
    end
    if (state == ST_WAIT) begin
      if (resp_in) begin
        rsp_dat <= up_rsp.rdata;
      end else if (expired) begin
        rsp_dat <= '0;
      end
    end
  end

  assign up_req = '{wreq: req_wr, waddr: req_addr, wdata: req_data,
                    rreq: req_rd, raddr: req_addr};
  assign wb_rsp = '{ack: rsp_ack, err: rsp_err, dat: rsp_dat};

endmodule
